/* verilog/cacheGeomPkg.sv */
package cacheGeomPkg;

    localparam int numLines = 32;
    localparam int numWays = 4;
    localparam int lineBytesLog = 7;
    localparam int numSets = numLines / numWays;

    localparam int setBits = $clog2(numSets);
    localparam int wayBits = $clog2(numWays);
    localparam int tagBits = 32 - lineBytesLog - setBits;

    // Word offset inside a line
    localparam int lineWordBits = lineBytesLog - 2;
    localparam int wordsPerLine = 1 << lineWordBits;

    localparam int mmioBit = 31;

    typedef logic [setBits-1:0] setIdx;
    typedef logic [wayBits-1:0] wayIdx;
    typedef logic [tagBits-1:0] lineTag;

    typedef struct packed {
        lineTag tag;
        logic valid;
        logic dirty;
        logic used;
    } tagEntry;

    typedef struct packed {
        logic hit;
        wayIdx hitWay;
        logic freeAvail;
        wayIdx freeWay;
        wayIdx victimWay;
        logic victimDirty;
    } lookupResult;

endpackage

/* verilog/memTrafficPkg.sv */
package memTrafficPkg;

    import cacheGeomPkg::*;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
        logic [5:0] id;
    } accessReq;

    // Address is the SRAM byte address for cached accesses
    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
        logic [5:0] id;
        logic isMmio;
    } accessResp;

    typedef enum logic [1:0] {
        memcNone,
        memcCacheToExt,
        memcExtToCache
    } memcCmd;

    // Both addresses count 32-bit words
    typedef struct packed {
        memcCmd cmd;
        logic [29:0] sramAddr;
        logic [29:0] extAddr;
    } memcCtrl;

    typedef struct packed {
        logic busy;
        logic [lineWordBits:0] progress;
    } memcStat;

    typedef enum logic [2:0] {
        seqIdle,
        seqEvictRq,
        seqEvictActive,
        seqLoadRq,
        seqLoadActive,
        seqReplaceRq,
        seqReplaceActive
    } lineOp;

    typedef struct packed {
        logic enable;
        setIdx set;
        wayIdx way;
        tagEntry entry;
    } tableWrite;

endpackage

/* verilog/tagTable.sv */
`timescale 1ns/10ps

module tagTable
    import cacheGeomPkg::*;
    import memTrafficPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic [31:0] addr0,
    input  logic [31:0] addr1,
    input  logic [1:0] otherStoreHit,
    // 0 sequencer, 1 flush, 2 port 0, 3 port 1
    input  tableWrite writes [4],
    input  logic [setBits+wayBits-1:0] walkIdx,
    output lookupResult result0,
    output lookupResult result1,
    output lineTag victimTag0,
    output lineTag victimTag1,
    output tagEntry entryOut
);

    tagEntry entries [numSets][numWays];
    setIdx set0;
    setIdx set1;

    function automatic lookupResult lookUp(input setIdx set, input lineTag tag,
                                           input tableWrite other, input logic otherStore);
        lookupResult r;
        r = '0;
        for (int w = 0; w < numWays; w++) begin
            if (entries[set][w].valid && entries[set][w].tag == tag) begin
                r.hit = 1'b1;
                r.hitWay = wayIdx'(w);
            end
            if (!entries[set][w].valid) begin
                r.freeAvail = 1'b1;
                r.freeWay = wayIdx'(w);
            end
            if (!entries[set][w].used)
                r.victimWay = wayIdx'(w);
        end
        // A store hit from the other port in this cycle dirties the line too
        r.victimDirty = entries[set][r.victimWay].dirty ||
            (otherStore && other.set == set && other.way == r.victimWay);
        return r;
    endfunction

    assign set0 = addr0[lineBytesLog +: setBits];
    assign set1 = addr1[lineBytesLog +: setBits];

    always_comb begin
        result0 = lookUp(set0, addr0[31 -: tagBits], writes[3], otherStoreHit[0]);
        result1 = lookUp(set1, addr1[31 -: tagBits], writes[2], otherStoreHit[1]);
        victimTag0 = entries[set0][result0.victimWay].tag;
        victimTag1 = entries[set1][result1.victimWay].tag;
        entryOut = entries[walkIdx[wayBits +: setBits]][walkIdx[wayBits-1:0]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < numSets; s++)
                for (int w = 0; w < numWays; w++)
                    entries[s][w] <= '0;
        end else begin
            // Lowest priority first so later writes win
            for (int p = 3; p >= 2; p--) begin
                if (writes[p].enable) begin
                    for (int w = 0; w < numWays; w++)
                        entries[writes[p].set][w].used <= 1'b0;
                    entries[writes[p].set][writes[p].way].used <= 1'b1;
                    if (writes[p].entry.dirty)
                        entries[writes[p].set][writes[p].way].dirty <= 1'b1;
                end
            end
            for (int p = 1; p >= 0; p--)
                if (writes[p].enable)
                    entries[writes[p].set][writes[p].way] <= writes[p].entry;
        end
    end

endmodule

/* verilog/accessPort.sv */
`timescale 1ns/10ps

module accessPort
    import cacheGeomPkg::*;
    import memTrafficPkg::*;
#(
    parameter bit isStore = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  accessReq req,
    input  logic hold,
    input  lookupResult lookup,
    input  logic flushing,
    input  logic granted,
    output accessResp resp,
    output logic stall,
    output logic miss,
    output tableWrite usedWrite,
    output logic [31:0] missAddr
);

    logic isMmio;
    logic isHit;
    logic isMiss;
    logic accept;
    logic filling;
    setIdx set;

    assign set = req.addr[lineBytesLog +: setBits];
    assign isMmio = req.valid && req.addr[mmioBit];
    assign isHit = req.valid && !req.addr[mmioBit] && lookup.hit;
    assign isMiss = req.valid && !req.addr[mmioBit] && !lookup.hit;

    assign stall = hold || flushing || isMiss;
    assign accept = req.valid && !stall;
    // Ask only once per miss
    assign miss = isMiss && !flushing && !filling;
    assign missAddr = req.addr;

    always_comb begin
        usedWrite = '0;
        usedWrite.enable = accept && isHit;
        usedWrite.set = set;
        usedWrite.way = lookup.hitWay;
        usedWrite.entry.tag = req.addr[31 -: tagBits];
        usedWrite.entry.valid = 1'b1;
        usedWrite.entry.dirty = isStore;
        usedWrite.entry.used = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp.valid <= 1'b0;
            filling <= 1'b0;
        end else begin
            if (granted)
                filling <= 1'b1;
            else if (!isMiss)
                filling <= 1'b0;

            if (!hold) begin
                resp.valid <= accept;
                resp.data <= req.data;
                resp.wmask <= req.wmask;
                resp.id <= req.id;
                resp.isMmio <= isMmio;
                if (isMmio)
                    resp.addr <= req.addr;
                else
                    resp.addr <= {{(32-lineBytesLog-setBits-wayBits){1'b0}},
                                  lookup.hitWay, set, req.addr[lineBytesLog-1:0]};
            end
        end
    end

endmodule

/* verilog/lineSequencer.sv */
`timescale 1ns/10ps

module lineSequencer
    import cacheGeomPkg::*;
    import memTrafficPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic miss0,
    input  logic miss1,
    input  logic [31:0] missAddr0,
    input  logic [31:0] missAddr1,
    input  lookupResult lookup0,
    input  lookupResult lookup1,
    input  lineTag victimTag0,
    input  lineTag victimTag1,
    input  logic wbReq,
    input  setIdx wbSet,
    input  wayIdx wbWay,
    input  lineTag wbTag,
    input  memcStat memcIn,
    output memcCtrl memcOut,
    output tableWrite fillWrite,
    output logic grant0,
    output logic grant1,
    output logic idle
);

    lineOp state;
    logic [29:0] pendingExt;
    lookupResult sel;
    logic [31:0] selAddr;
    lineTag selVictimTag;
    setIdx selSet;
    wayIdx fillWay;
    setIdx curSet;
    wayIdx curWay;
    logic xferDone;

    function automatic logic [29:0] sramLine(input wayIdx way, input setIdx set);
        return {{(30-wayBits-setBits-lineWordBits){1'b0}}, way, set, {lineWordBits{1'b0}}};
    endfunction

    function automatic logic [29:0] extLine(input lineTag tag, input setIdx set);
        return {tag, set, {lineWordBits{1'b0}}};
    endfunction

    assign idle = state == seqIdle;
    assign grant0 = idle && !wbReq && miss0;
    assign grant1 = idle && !wbReq && !miss0 && miss1;

    assign sel = grant0 ? lookup0 : lookup1;
    assign selAddr = grant0 ? missAddr0 : missAddr1;
    assign selVictimTag = grant0 ? victimTag0 : victimTag1;
    assign selSet = selAddr[lineBytesLog +: setBits];
    assign fillWay = sel.freeAvail ? sel.freeWay : sel.victimWay;

    assign curSet = memcOut.sramAddr[lineWordBits +: setBits];
    assign curWay = memcOut.sramAddr[lineWordBits + setBits +: wayBits];
    assign xferDone = !memcIn.busy || memcIn.progress == wordsPerLine;

    always_comb begin
        fillWrite = '0;
        if (state == seqLoadActive && xferDone) begin
            fillWrite.enable = 1'b1;
            fillWrite.set = curSet;
            fillWrite.way = curWay;
            fillWrite.entry.tag = memcOut.extAddr[29 -: tagBits];
            fillWrite.entry.valid = 1'b1;
        end else if ((grant0 || grant1) && !sel.freeAvail) begin
            // Victim goes invalid as soon as the miss is taken
            fillWrite.enable = 1'b1;
            fillWrite.set = selSet;
            fillWrite.way = sel.victimWay;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            memcOut.cmd <= memcNone;
        end else begin
            case (state)
                seqIdle: begin
                    if (wbReq) begin
                        memcOut.cmd <= memcCacheToExt;
                        memcOut.sramAddr <= sramLine(wbWay, wbSet);
                        memcOut.extAddr <= extLine(wbTag, wbSet);
                        state <= seqEvictRq;
                    end else if (grant0 || grant1) begin
                        if (!sel.freeAvail && sel.victimDirty) begin
                            memcOut.cmd <= memcCacheToExt;
                            memcOut.extAddr <= extLine(selVictimTag, selSet);
                            pendingExt <= extLine(selAddr[31 -: tagBits], selSet);
                            state <= seqReplaceRq;
                        end else begin
                            memcOut.cmd <= memcExtToCache;
                            memcOut.extAddr <= extLine(selAddr[31 -: tagBits], selSet);
                            state <= seqLoadRq;
                        end
                        memcOut.sramAddr <= sramLine(fillWay, selSet);
                    end
                end
                seqEvictRq: begin
                    if (memcIn.busy) begin
                        memcOut.cmd <= memcNone;
                        state <= seqEvictActive;
                    end
                end
                seqLoadRq: begin
                    if (memcIn.busy) begin
                        memcOut.cmd <= memcNone;
                        state <= seqLoadActive;
                    end
                end
                seqReplaceRq: begin
                    if (memcIn.busy) begin
                        memcOut.cmd <= memcNone;
                        state <= seqReplaceActive;
                    end
                end
                seqEvictActive,
                seqLoadActive: begin
                    if (xferDone)
                        state <= seqIdle;
                end
                seqReplaceActive: begin
                    // Fetch the requested line into the same SRAM line
                    if (xferDone) begin
                        memcOut.cmd <= memcExtToCache;
                        memcOut.extAddr <= pendingExt;
                        state <= seqLoadRq;
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

endmodule

/* verilog/flushWalker.sv */
`timescale 1ns/10ps

module flushWalker
    import cacheGeomPkg::*;
    import memTrafficPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic fence,
    input  logic portsIdle,
    input  logic seqIdle,
    input  tagEntry entry,
    output logic [setBits+wayBits-1:0] walkIdx,
    output logic flushing,
    output logic fenceBusy,
    output logic wbReq,
    output tableWrite flushWrite
);

    logic waiting;
    logic [setBits+wayBits:0] walkCnt;
    logic walkDone;
    logic advance;

    assign walkIdx = walkCnt[setBits+wayBits-1:0];
    assign walkDone = walkCnt[setBits+wayBits];
    assign wbReq = flushing && !walkDone && entry.valid && entry.dirty && seqIdle;
    // Dirty lines wait for the sequencer to take the write-back
    assign advance = flushing && !walkDone && (!entry.valid || !entry.dirty || seqIdle);
    assign fenceBusy = fence || waiting || flushing;

    always_comb begin
        flushWrite = '0;
        flushWrite.enable = advance && entry.valid;
        flushWrite.set = walkIdx[wayBits +: setBits];
        flushWrite.way = walkIdx[wayBits-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting <= 1'b0;
            flushing <= 1'b0;
            walkCnt <= '0;
        end else begin
            if (fence && !flushing) begin
                waiting <= 1'b1;
            end else if (waiting && portsIdle && seqIdle) begin
                waiting <= 1'b0;
                flushing <= 1'b1;
                walkCnt <= '0;
            end else if (flushing && walkDone && seqIdle) begin
                flushing <= 1'b0;
            end
            if (advance)
                walkCnt <= walkCnt + 1'b1;
        end
    end

endmodule

/* verilog/cacheController.sv */
`timescale 1ns/10ps

module cacheController
    import cacheGeomPkg::*;
    import memTrafficPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  accessReq ldReq,
    input  accessReq stReq,
    input  logic ldHold,
    input  logic stHold,
    input  logic fence,
    input  memcStat memcIn,
    output logic ldStall,
    output logic stStall,
    output accessResp ldResp,
    output accessResp stResp,
    output memcCtrl memcOut,
    output logic fenceBusy
);

    lookupResult ldLook;
    lookupResult stLook;
    lineTag ldVictimTag;
    lineTag stVictimTag;
    logic [31:0] ldMissAddr;
    logic [31:0] stMissAddr;
    logic ldMiss;
    logic stMiss;
    logic ldGrant;
    logic stGrant;
    logic seqIdle;
    logic flushing;
    logic wbReq;
    logic [setBits+wayBits-1:0] walkIdx;
    tagEntry walkEntry;
    tableWrite seqWrite;
    tableWrite walkWrite;
    tableWrite ldUsedWrite;
    tableWrite stUsedWrite;
    tableWrite writes [4];

    // Table write priority order
    assign writes[0] = seqWrite;
    assign writes[1] = walkWrite;
    assign writes[2] = ldUsedWrite;
    assign writes[3] = stUsedWrite;

    accessPort #(.isStore(1'b0)) i_ldPort (
        .clk(clk), .rst(rst), .req(ldReq), .hold(ldHold), .lookup(ldLook),
        .flushing(flushing), .granted(ldGrant), .resp(ldResp), .stall(ldStall),
        .miss(ldMiss), .usedWrite(ldUsedWrite), .missAddr(ldMissAddr)
    );

    accessPort #(.isStore(1'b1)) i_stPort (
        .clk(clk), .rst(rst), .req(stReq), .hold(stHold), .lookup(stLook),
        .flushing(flushing), .granted(stGrant), .resp(stResp), .stall(stStall),
        .miss(stMiss), .usedWrite(stUsedWrite), .missAddr(stMissAddr)
    );

    tagTable i_tagTable (
        .clk(clk), .rst(rst), .addr0(ldReq.addr), .addr1(stReq.addr),
        .otherStoreHit({ldUsedWrite.enable && ldUsedWrite.entry.dirty,
                        stUsedWrite.enable && stUsedWrite.entry.dirty}),
        .writes(writes), .walkIdx(walkIdx), .result0(ldLook), .result1(stLook),
        .victimTag0(ldVictimTag), .victimTag1(stVictimTag), .entryOut(walkEntry)
    );

    lineSequencer i_lineSequencer (
        .clk(clk), .rst(rst), .miss0(ldMiss), .miss1(stMiss),
        .missAddr0(ldMissAddr), .missAddr1(stMissAddr), .lookup0(ldLook), .lookup1(stLook),
        .victimTag0(ldVictimTag), .victimTag1(stVictimTag), .wbReq(wbReq),
        .wbSet(walkIdx[wayBits +: setBits]), .wbWay(walkIdx[wayBits-1:0]),
        .wbTag(walkEntry.tag), .memcIn(memcIn), .memcOut(memcOut), .fillWrite(seqWrite),
        .grant0(ldGrant), .grant1(stGrant), .idle(seqIdle)
    );

    flushWalker i_flushWalker (
        .clk(clk), .rst(rst), .fence(fence), .portsIdle(!ldReq.valid && !stReq.valid),
        .seqIdle(seqIdle), .entry(walkEntry), .walkIdx(walkIdx), .flushing(flushing),
        .fenceBusy(fenceBusy), .wbReq(wbReq), .flushWrite(walkWrite)
    );

endmodule

/* tests/cacheChecker.sv */
`timescale 1ns/10ps

module cacheChecker
    import cacheGeomPkg::*;
    import memTrafficPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  accessReq ldReq,
    input  accessReq stReq,
    input  logic ldStall,
    input  logic stStall,
    input  logic ldHold,
    input  logic stHold,
    input  accessResp ldResp,
    input  accessResp stResp,
    input  memcCtrl memcOut,
    input  logic fenceBusy,
    input  logic rowDone,
    input  logic [1:0] expFill,
    input  logic [2:0] expWb,
    output int errors,
    output int checks
);

    // Shadow copy of the tag table built from observed commands
    lineTag shadowTag [numSets][numWays];
    logic shadowValid [numSets][numWays];
    logic shadowDirty [numSets][numWays];
    accessResp ldExp [$];
    accessResp stExp [$];
    accessResp ldPrev;
    accessResp stPrev;
    logic ldHeldPrev;
    logic stHeldPrev;
    memcCmd prevCmd;
    logic prevFenceBusy;
    int fillCnt;
    int wbCnt;

    function automatic void reportError(input string msg);
        errors++;
        $display("error %0t ns: %s", $time, msg);
    endfunction

    function automatic logic findLine(input logic [29:0] lineWord, output wayIdx way);
        setIdx set;
        lineTag tag;
        logic found;
        set = lineWord[lineWordBits +: setBits];
        tag = lineWord[29 -: tagBits];
        found = 1'b0;
        way = '0;
        for (int w = 0; w < numWays; w++) begin
            if (shadowValid[set][w] && shadowTag[set][w] == tag) begin
                found = 1'b1;
                way = wayIdx'(w);
            end
        end
        return found;
    endfunction

    function automatic accessResp expectedResp(input accessReq req, input logic isStore);
        accessResp r;
        setIdx set;
        wayIdx way;
        set = req.addr[lineBytesLog +: setBits];
        r.valid = 1'b1;
        r.addr = req.addr;
        r.data = req.data;
        r.wmask = req.wmask;
        r.id = req.id;
        r.isMmio = req.addr[mmioBit];
        if (!r.isMmio) begin
            if (!findLine(req.addr[31:2], way))
                reportError($sformatf("accepted access to uncached address %h", req.addr));
            // SRAM byte address is way, set and offset
            r.addr = '0;
            r.addr[lineBytesLog-1:0] = req.addr[lineBytesLog-1:0];
            r.addr[lineBytesLog +: setBits] = set;
            r.addr[lineBytesLog+setBits +: wayBits] = way;
            if (isStore)
                shadowDirty[set][way] = 1'b1;
        end
        return r;
    endfunction

    function automatic void checkResp(input string port, input accessResp got,
                                      input accessResp exp);
        checks++;
        if (got !== exp)
            reportError($sformatf("%s response %h, expected %h", port, got, exp));
    endfunction

    function automatic void checkCommand();
        setIdx set;
        wayIdx way;
        lineTag tag;
        wayIdx other;
        set = memcOut.sramAddr[lineWordBits +: setBits];
        way = memcOut.sramAddr[lineWordBits+setBits +: wayBits];
        tag = memcOut.extAddr[29 -: tagBits];
        checks++;
        if (memcOut.sramAddr[lineWordBits-1:0] != 0 || memcOut.extAddr[lineWordBits-1:0] != 0 ||
            memcOut.sramAddr[29:lineWordBits+setBits+wayBits] != 0 ||
            memcOut.extAddr[lineWordBits +: setBits] != set)
            reportError($sformatf("bad line addresses sram %h ext %h",
                                  memcOut.sramAddr, memcOut.extAddr));
        if (memcOut.cmd == memcExtToCache) begin
            fillCnt++;
            if (!(ldReq.valid && ldReq.addr[31:lineBytesLog] == memcOut.extAddr[29:lineWordBits]) &&
                !(stReq.valid && stReq.addr[31:lineBytesLog] == memcOut.extAddr[29:lineWordBits]))
                reportError($sformatf("fill of line %h that no port waits for", memcOut.extAddr));
            if (findLine(memcOut.extAddr, other))
                reportError($sformatf("fill of line %h already cached", memcOut.extAddr));
            if (shadowValid[set][way] && shadowDirty[set][way])
                reportError($sformatf("fill over dirty set %0d way %0d", set, way));
            shadowTag[set][way] = tag;
            shadowValid[set][way] = 1'b1;
            shadowDirty[set][way] = 1'b0;
        end else begin
            wbCnt++;
            if (!shadowValid[set][way] || !shadowDirty[set][way] || shadowTag[set][way] != tag)
                reportError($sformatf("write-back of clean or wrong line %h", memcOut.extAddr));
            shadowDirty[set][way] = 1'b0;
        end
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < numSets; s++) begin
                for (int w = 0; w < numWays; w++) begin
                    shadowValid[s][w] = 1'b0;
                    shadowDirty[s][w] = 1'b0;
                end
            end
            ldExp.delete();
            stExp.delete();
            ldHeldPrev = 1'b0;
            stHeldPrev = 1'b0;
            prevCmd = memcNone;
            prevFenceBusy = 1'b0;
            fillCnt = 0;
            wbCnt = 0;
            errors = 0;
            checks = 0;
        end else begin
            if (rowDone) begin
                checks++;
                if (fillCnt != expFill || wbCnt != expWb)
                    reportError($sformatf("%0d fills and %0d write-backs, expected %0d and %0d",
                                          fillCnt, wbCnt, expFill, expWb));
                if (ldExp.size() + stExp.size() != 0)
                    reportError("accepted request got no response");
                fillCnt = 0;
                wbCnt = 0;
            end

            if (memcOut.cmd != memcNone && prevCmd == memcNone)
                checkCommand();
            prevCmd = memcOut.cmd;

            // A held register keeps its value across the edge
            if (ldHeldPrev && ldResp !== ldPrev)
                reportError("load response changed while held");
            if (stHeldPrev && stResp !== stPrev)
                reportError("store response changed while held");
            ldHeldPrev = ldHold && ldResp.valid;
            stHeldPrev = stHold && stResp.valid;
            ldPrev = ldResp;
            stPrev = stResp;

            if (ldResp.valid && !ldHold) begin
                if (ldExp.size() == 0)
                    reportError("load response without request");
                else
                    checkResp("load", ldResp, ldExp.pop_front());
            end
            if (stResp.valid && !stHold) begin
                if (stExp.size() == 0)
                    reportError("store response without request");
                else
                    checkResp("store", stResp, stExp.pop_front());
            end

            if (ldReq.valid && !ldStall)
                ldExp.push_back(expectedResp(ldReq, 1'b0));
            if (stReq.valid && !stStall)
                stExp.push_back(expectedResp(stReq, 1'b1));

            // No dirty line may remain once the flush ends
            if (prevFenceBusy && !fenceBusy) begin
                checks++;
                for (int s = 0; s < numSets; s++) begin
                    for (int w = 0; w < numWays; w++) begin
                        if (shadowValid[s][w] && shadowDirty[s][w])
                            reportError($sformatf("set %0d way %0d dirty after flush", s, w));
                        shadowValid[s][w] = 1'b0;
                        shadowDirty[s][w] = 1'b0;
                    end
                end
            end
            prevFenceBusy = fenceBusy;
        end
    end

endmodule

/* tests/cacheControllerTb.sv */
`timescale 1ns/10ps

module cacheControllerTb
    import cacheGeomPkg::*;
    import memTrafficPkg::*;
();

    typedef struct packed {
        logic isStore;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] mask;
        logic [3:0] hold;
        logic fence;
        logic [1:0] expFill;
        logic [2:0] expWb;
    } stimRow;

    logic clk;
    logic rst;
    accessReq ldReq;
    accessReq stReq;
    logic ldHold;
    logic stHold;
    logic fence;
    memcStat memcIn;
    logic ldStall;
    logic stStall;
    accessResp ldResp;
    accessResp stResp;
    memcCtrl memcOut;
    logic fenceBusy;
    logic rowDone;
    logic [1:0] expFill;
    logic [2:0] expWb;
    int errors;
    int checks;
    stimRow rows [$];
    logic [31:0] rngState;
    logic [1:0] memcWait;
    int cycles = 0;
    int cycleLimit = 0;

    cacheController i_dut (
        .clk(clk), .rst(rst), .ldReq(ldReq), .stReq(stReq), .ldHold(ldHold),
        .stHold(stHold), .fence(fence), .memcIn(memcIn), .ldStall(ldStall),
        .stStall(stStall), .ldResp(ldResp), .stResp(stResp), .memcOut(memcOut),
        .fenceBusy(fenceBusy)
    );

    cacheChecker i_checker (
        .clk(clk), .rst(rst), .ldReq(ldReq), .stReq(stReq), .ldStall(ldStall),
        .stStall(stStall), .ldHold(ldHold), .stHold(stHold), .ldResp(ldResp),
        .stResp(stResp), .memcOut(memcOut), .fenceBusy(fenceBusy), .rowDone(rowDone),
        .expFill(expFill), .expWb(expWb), .errors(errors), .checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory controller model goes busy two cycles after a command
    always @(posedge clk) begin
        if (rst) begin
            memcWait <= 2'd0;
            memcIn <= #1 '0;
        end else if (memcIn.busy) begin
            if (memcIn.progress == wordsPerLine)
                memcIn <= #1 '0;
            else
                memcIn.progress <= #1 memcIn.progress + 1'b1;
        end else if (memcWait != 0) begin
            memcWait <= memcWait - 1'b1;
            if (memcWait == 2'd1)
                memcIn.busy <= #1 1'b1;
        end else if (memcOut.cmd != memcNone) begin
            memcWait <= 2'd2;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    function automatic logic [31:0] lineAddr(input int tag, input int set, input int offset);
        return (tag << (lineBytesLog + setBits)) | (set << lineBytesLog) | offset;
    endfunction

    task automatic addRow(input logic isStore, input logic [31:0] addr, input logic [3:0] mask,
                          input int hold, input logic isFence, input int fills, input int wbs);
        stimRow row;
        row.isStore = isStore;
        row.addr = addr;
        row.data = nextRandom();
        row.mask = mask;
        row.hold = hold[3:0];
        row.fence = isFence;
        row.expFill = fills[1:0];
        row.expWb = wbs[2:0];
        rows.push_back(row);
    endtask

    task automatic buildTable();
        // Loads into set 0 where the fifth line evicts a clean victim
        addRow(1'b0, lineAddr(1, 0, 'h04), 4'h0, 0, 1'b0, 1, 0);
        addRow(1'b0, lineAddr(1, 0, 'h08), 4'h0, 0, 1'b0, 0, 0);
        addRow(1'b0, lineAddr(2, 0, 'h00), 4'h0, 0, 1'b0, 1, 0);
        addRow(1'b0, lineAddr(3, 0, 'h00), 4'h0, 0, 1'b0, 1, 0);
        addRow(1'b0, lineAddr(4, 0, 'h00), 4'h0, 0, 1'b0, 1, 0);
        addRow(1'b0, lineAddr(5, 0, 'h10), 4'h0, 0, 1'b0, 1, 0);
        addRow(1'b0, lineAddr(5, 0, 'h14), 4'h0, 0, 1'b0, 0, 0);
        // Stores into set 1 where every victim is dirty
        addRow(1'b1, lineAddr(1, 1, 'h00), 4'hf, 0, 1'b0, 1, 0);
        addRow(1'b1, lineAddr(2, 1, 'h00), 4'hf, 0, 1'b0, 1, 0);
        addRow(1'b1, lineAddr(3, 1, 'h00), 4'hf, 0, 1'b0, 1, 0);
        addRow(1'b1, lineAddr(4, 1, 'h00), 4'hf, 0, 1'b0, 1, 0);
        addRow(1'b1, lineAddr(5, 1, 'h00), 4'hf, 0, 1'b0, 1, 1);
        addRow(1'b0, 32'h8000_0010, 4'h0, 1, 1'b0, 0, 0);
        addRow(1'b1, 32'h8000_0020, 4'h3, 0, 1'b0, 0, 0);
        addRow(1'b0, lineAddr(5, 0, 'h18), 4'h0, 3, 1'b0, 0, 0);
        addRow(1'b1, lineAddr(5, 1, 'h04), 4'hc, 2, 1'b0, 0, 0);
        addRow(1'b0, 32'h0, 4'h0, 0, 1'b1, 0, 4);
        addRow(1'b0, lineAddr(5, 0, 'h00), 4'h0, 0, 1'b0, 1, 0);
        addRow(1'b1, lineAddr(5, 1, 'h08), 4'hf, 0, 1'b0, 1, 0);
        addRow(1'b0, 32'h0, 4'h0, 0, 1'b1, 0, 1);
    endtask

    task automatic runRow(input stimRow row, input int idx);
        accessReq req;
        req.valid = 1'b1;
        req.addr = row.addr;
        req.data = row.data;
        req.wmask = row.mask;
        req.id = idx[5:0];
        if (row.fence) begin
            fence = 1'b1;
            @(posedge clk);
            #1 fence = 1'b0;
            @(posedge clk);
            while (fenceBusy)
                @(posedge clk);
        end else begin
            if (row.isStore)
                stReq = req;
            else
                ldReq = req;
            @(posedge clk);
            while (row.isStore ? stStall : ldStall)
                @(posedge clk);
            #1;
            ldReq = '0;
            stReq = '0;
            if (row.hold != 0) begin
                if (row.isStore)
                    stHold = 1'b1;
                else
                    ldHold = 1'b1;
                repeat (row.hold) @(posedge clk);
                #1;
                ldHold = 1'b0;
                stHold = 1'b0;
            end
            @(posedge clk);
        end
        #1;
        rowDone = 1'b1;
        expFill = row.expFill;
        expWb = row.expWb;
        @(posedge clk);
        #1 rowDone = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        ldReq = '0;
        stReq = '0;
        ldHold = 1'b0;
        stHold = 1'b0;
        fence = 1'b0;
        memcIn = '0;
        rowDone = 1'b0;
        expFill = '0;
        expWb = '0;
        rngState = 32'd48578;
        buildTable();
        cycleLimit = 400 * rows.size();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        foreach (rows[i])
            runRow(rows[i], i);
        repeat (4) @(posedge clk);
        $display("Done: %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* project.f */
verilog/cacheGeomPkg.sv
verilog/memTrafficPkg.sv
verilog/tagTable.sv
verilog/accessPort.sv
verilog/lineSequencer.sv
verilog/flushWalker.sv
verilog/cacheController.sv
tests/cacheChecker.sv
tests/cacheControllerTb.sv

/* Bender.yml */
package:
  name: cacheController

sources:
  - verilog/cacheGeomPkg.sv
  - verilog/memTrafficPkg.sv
  - verilog/tagTable.sv
  - verilog/accessPort.sv
  - verilog/lineSequencer.sv
  - verilog/flushWalker.sv
  - verilog/cacheController.sv
  - target: test
    files:
      - tests/cacheChecker.sv
      - tests/cacheControllerTb.sv
